//--- build.f
design/decode_pkg.sv
design/i_decoder.sv
design/m_decoder.sv
design/decoder.sv
design/decode_cfg_regs.sv
design/decode_stage.sv
verif/decode_checker.sv
verif/tb_decode_stage.sv

//--- design/decode_cfg_regs.sv
`timescale 1ns/10ps

module decode_cfg_regs import decode_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,       // Word address
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        ill_evt_i,      // Illegal word accepted this edge
  input  logic [31:0] ill_word_i,
  output logic        rv32e_o,
  output logic        m_en_o
);

  logic                     wb_req;      // New access, not yet acked
  logic                     wb_wr;
  logic                     cnt_clr;
  logic                     cnt_sat;     // Counter at all ones
  logic [1:0]               cfg_q;
  logic [ILL_CNT_WIDTH-1:0] ill_cnt_q;
  logic [31:0]              ill_last_q;
  logic [31:0]              rdata;

  assign wb_req  = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wb_wr   = wb_req && wb_we_i;
  assign cnt_clr = wb_wr && (wb_adr_i == REG_ILL_CNT);
  assign cnt_sat = &ill_cnt_q;

  ////////////////////////////////////////
  // Wishbone handshake
  ////////////////////////////////////////

  // Single cycle ack, so every access is two cycles
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
    end
  end

  // Read data lands on the ack edge
  always_ff @(posedge clk) begin
    if (wb_req && !wb_we_i) begin
      wb_dat_o <= rdata;
    end
  end

  always_comb begin
    case (wb_adr_i)
      REG_CFG:      rdata = {30'd0, cfg_q};
      REG_ILL_CNT:  rdata = {{(32 - ILL_CNT_WIDTH){1'b0}}, ill_cnt_q};
      REG_ILL_LAST: rdata = ill_last_q;
      default:      rdata = 32'd0;                           // Address 3 unused
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfg_q <= CFG_RESET;
    end else if (wb_wr && (wb_adr_i == REG_CFG)) begin
      cfg_q <= wb_dat_i[1:0];
    end
  end

  // Clear wins, but an event on the same edge still counts
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ill_cnt_q <= '0;
    end else if (cnt_clr) begin
      ill_cnt_q <= {{(ILL_CNT_WIDTH - 1){1'b0}}, ill_evt_i};
    end else if (ill_evt_i && !cnt_sat) begin
      ill_cnt_q <= ill_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ill_last_q <= 32'd0;
    end else if (ill_evt_i) begin
      ill_last_q <= ill_word_i;                              // Keep most recent offender
    end
  end

  assign rv32e_o = cfg_q[CFG_RV32E_BIT];
  assign m_en_o  = cfg_q[CFG_M_EN_BIT];

endmodule

//--- design/decode_pkg.sv
package decode_pkg;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;
  localparam logic [6:0] OPC_FENCE  = 7'h0f;

  // ALU ops, compare ops share the same field
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0, ALU_SUB  = 4'h1, ALU_SLL = 4'h2, ALU_SLT = 4'h3,
    ALU_SLTU = 4'h4, ALU_XOR  = 4'h5, ALU_SRL = 4'h6, ALU_SRA = 4'h7,
    ALU_OR   = 4'h8, ALU_AND  = 4'h9, ALU_EQ  = 4'ha, ALU_NE  = 4'hb,
    ALU_LT   = 4'hc, ALU_GE   = 4'hd, ALU_LTU = 4'he, ALU_GEU = 4'hf
  } alu_opcode_e;

  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_opcode_e;   // funct3[1:0]
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_opcode_e;       // funct3[1:0]
  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_opcode_e;
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;                 // 2'b11 unused

  // Control set shared by I and M decoders and the combining decoder
  typedef struct packed {
    logic        alu_en;
    alu_opcode_e alu_operator;
    logic        mul_en;
    mul_opcode_e mul_operator;
    logic        div_en;
    div_opcode_e div_operator;
    logic        lsu_en;
    logic        lsu_we;
    lsu_size_e   lsu_size;
    logic        lsu_sext;
    logic        rf_we;       // rd written
    logic [1:0]  rf_re;       // Bit 0 rs1, bit 1 rs2
    logic        csr_en;
    csr_opcode_e csr_op;
    logic        sys_en;      // Any system group op
    logic        sys_ecall;
    logic        sys_ebrk;
    logic        sys_mret;
    logic        sys_wfi;
    logic        sys_fence;
    logic        illegal_insn;
  } decoder_ctrl_t;

  // All enables low, all operators at their zero encoding
  localparam decoder_ctrl_t DECODER_CTRL_NONE = '{
    alu_operator: ALU_ADD, mul_operator: MUL_MUL, div_operator: DIV_DIV,
    lsu_size: LSU_BYTE, csr_op: CSR_OP_READ, default: '0
  };

  // No match from a decoder
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_operator: ALU_ADD, mul_operator: MUL_MUL, div_operator: DIV_DIV,
    lsu_size: LSU_BYTE, csr_op: CSR_OP_READ, illegal_insn: 1'b1, default: '0
  };

  ////////////////////////////////////////
  // Config block register map
  ////////////////////////////////////////

  localparam logic [1:0] REG_CFG      = 2'd0;   // rv32e / m_en
  localparam logic [1:0] REG_ILL_CNT  = 2'd1;   // Saturating illegal count, write clears
  localparam logic [1:0] REG_ILL_LAST = 2'd2;   // Last illegal word, read only

  localparam int unsigned CFG_RV32E_BIT = 0;
  localparam int unsigned CFG_M_EN_BIT  = 1;
  localparam logic [1:0]  CFG_RESET     = 2'b10;   // RV32I with M
  localparam int unsigned ILL_CNT_WIDTH = 16;

endpackage

//--- design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import decode_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        fetch_err_i,
  input  logic        stall_i,          // Back-pressure from EX
  output logic        dec_valid_o,
  output logic        illegal_insn_o,
  output logic        alu_en_o,
  output alu_opcode_e alu_operator_o,
  output logic        mul_en_o,
  output mul_opcode_e mul_operator_o,
  output logic        div_en_o,
  output div_opcode_e div_operator_o,
  output logic        lsu_en_o,
  output logic        lsu_we_o,
  output lsu_size_e   lsu_size_o,
  output logic        lsu_sext_o,
  output logic        rf_we_o,
  output logic [1:0]  rf_re_o,
  output logic        csr_en_o,
  output csr_opcode_e csr_op_o,
  output logic        sys_ecall_o,
  output logic        sys_ebrk_o,
  output logic        sys_mret_o,
  output logic        sys_wfi_o,
  output logic        sys_fence_o,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic          accept;      // Instruction taken this edge
  logic          ill_evt;
  logic          rv32e;
  logic          m_en;
  decoder_ctrl_t dec_d;       // Combinational decode
  decoder_ctrl_t dec_q;       // ID/EX register

  assign accept  = instr_valid_i && !stall_i;
  assign ill_evt = accept && dec_d.illegal_insn;   // Fetch errors never reach here as illegal

  decoder u_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .fetch_err_i    (fetch_err_i),
    .rv32e_i        (rv32e),
    .m_en_i         (m_en),
    .illegal_insn_o (dec_d.illegal_insn),
    .alu_en_o       (dec_d.alu_en),
    .alu_operator_o (dec_d.alu_operator),
    .mul_en_o       (dec_d.mul_en),
    .mul_operator_o (dec_d.mul_operator),
    .div_en_o       (dec_d.div_en),
    .div_operator_o (dec_d.div_operator),
    .lsu_en_o       (dec_d.lsu_en),
    .lsu_we_o       (dec_d.lsu_we),
    .lsu_size_o     (dec_d.lsu_size),
    .lsu_sext_o     (dec_d.lsu_sext),
    .rf_we_o        (dec_d.rf_we),
    .rf_re_o        (dec_d.rf_re),
    .csr_en_o       (dec_d.csr_en),
    .csr_op_o       (dec_d.csr_op),
    .sys_ecall_o    (dec_d.sys_ecall),
    .sys_ebrk_o     (dec_d.sys_ebrk),
    .sys_mret_o     (dec_d.sys_mret),
    .sys_wfi_o      (dec_d.sys_wfi),
    .sys_fence_o    (dec_d.sys_fence)
  );

  // Group bit rebuilt from the individual flags
  assign dec_d.sys_en = dec_d.sys_ecall | dec_d.sys_ebrk | dec_d.sys_mret |
                        dec_d.sys_wfi | dec_d.sys_fence;

  decode_cfg_regs u_cfg_regs (
    .clk        (clk),
    .reset_i    (reset_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .ill_evt_i  (ill_evt),
    .ill_word_i (instr_rdata_i),
    .rv32e_o    (rv32e),
    .m_en_o     (m_en)
  );

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  // Load on accept, bubble when idle, hold while stalled
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
      dec_q       <= DECODER_CTRL_NONE;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
      dec_q       <= dec_d;
    end else if (!stall_i) begin
      dec_valid_o <= 1'b0;
      dec_q       <= DECODER_CTRL_NONE;
    end
  end

  assign illegal_insn_o = dec_q.illegal_insn;
  assign alu_en_o       = dec_q.alu_en;
  assign alu_operator_o = dec_q.alu_operator;
  assign mul_en_o       = dec_q.mul_en;
  assign mul_operator_o = dec_q.mul_operator;
  assign div_en_o       = dec_q.div_en;
  assign div_operator_o = dec_q.div_operator;
  assign lsu_en_o       = dec_q.lsu_en;
  assign lsu_we_o       = dec_q.lsu_we;
  assign lsu_size_o     = dec_q.lsu_size;
  assign lsu_sext_o     = dec_q.lsu_sext;
  assign rf_we_o        = dec_q.rf_we;
  assign rf_re_o        = dec_q.rf_re;
  assign csr_en_o       = dec_q.csr_en;
  assign csr_op_o       = dec_q.csr_op;
  assign sys_ecall_o    = dec_q.sys_ecall;
  assign sys_ebrk_o     = dec_q.sys_ebrk;
  assign sys_mret_o     = dec_q.sys_mret;
  assign sys_wfi_o      = dec_q.sys_wfi;
  assign sys_fence_o    = dec_q.sys_fence;

endmodule

//--- design/decoder.sv
`timescale 1ns/10ps

module decoder import decode_pkg::*; (
  input  logic [31:0] instr_rdata_i,
  input  logic        fetch_err_i,      // Fetch failed on this word
  input  logic        rv32e_i,          // 16 GPR mode
  input  logic        m_en_i,
  output logic        illegal_insn_o,
  output logic        alu_en_o,
  output alu_opcode_e alu_operator_o,
  output logic        mul_en_o,
  output mul_opcode_e mul_operator_o,
  output logic        div_en_o,
  output div_opcode_e div_operator_o,
  output logic        lsu_en_o,
  output logic        lsu_we_o,
  output lsu_size_e   lsu_size_o,
  output logic        lsu_sext_o,
  output logic        rf_we_o,
  output logic [1:0]  rf_re_o,
  output logic        csr_en_o,
  output csr_opcode_e csr_op_o,
  output logic        sys_ecall_o,
  output logic        sys_ebrk_o,
  output logic        sys_mret_o,
  output logic        sys_wfi_o,
  output logic        sys_fence_o
);

  decoder_ctrl_t i_ctrl;      // RV32I candidate
  decoder_ctrl_t m_ctrl;      // RV32M candidate
  decoder_ctrl_t i_chk;       // After the RV32E check
  decoder_ctrl_t m_chk;
  decoder_ctrl_t sel;
  logic          rd_hi;       // x16 and up in rd
  logic          rs1_hi;
  logic          rs2_hi;
  logic          i_e_bad;     // Used field out of range under RV32E
  logic          m_e_bad;

  assign rd_hi  = instr_rdata_i[11];
  assign rs1_hi = instr_rdata_i[19];
  assign rs2_hi = instr_rdata_i[24];

  i_decoder u_i_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (i_ctrl)
  );

  m_decoder u_m_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .m_en_i         (m_en_i),
    .decoder_ctrl_o (m_ctrl)
  );

  ////////////////////////////////////////
  // RV32E register check
  ////////////////////////////////////////

  // Only fields the format reads or writes count
  assign i_e_bad = rv32e_i && ((i_ctrl.rf_we && rd_hi) ||
                               (i_ctrl.rf_re[0] && rs1_hi) ||
                               (i_ctrl.rf_re[1] && rs2_hi));
  assign m_e_bad = rv32e_i && ((m_ctrl.rf_we && rd_hi) ||
                               (m_ctrl.rf_re[0] && rs1_hi) ||
                               (m_ctrl.rf_re[1] && rs2_hi));

  assign i_chk = i_e_bad ? DECODER_CTRL_ILLEGAL : i_ctrl;
  assign m_chk = m_e_bad ? DECODER_CTRL_ILLEGAL : m_ctrl;

  // M wins when legal; an illegal I result is already the illegal set
  always_comb begin
    if (fetch_err_i) begin
      sel = DECODER_CTRL_NONE;           // Illegal and all enables deasserted
    end else if (!m_chk.illegal_insn) begin
      sel = m_chk;
    end else begin
      sel = i_chk;
    end
  end

  assign illegal_insn_o = sel.illegal_insn;
  assign alu_en_o       = sel.alu_en;
  assign alu_operator_o = sel.alu_operator;
  assign mul_en_o       = sel.mul_en;
  assign mul_operator_o = sel.mul_operator;
  assign div_en_o       = sel.div_en;
  assign div_operator_o = sel.div_operator;
  assign lsu_en_o       = sel.lsu_en;
  assign lsu_we_o       = sel.lsu_we;
  assign lsu_size_o     = sel.lsu_size;
  assign lsu_sext_o     = sel.lsu_sext;
  assign rf_we_o        = sel.rf_we;
  assign rf_re_o        = sel.rf_re;
  assign csr_en_o       = sel.csr_en;
  assign csr_op_o       = sel.csr_op;
  assign sys_ecall_o    = sel.sys_ecall;
  assign sys_ebrk_o     = sel.sys_ebrk;
  assign sys_mret_o     = sel.sys_mret;
  assign sys_wfi_o      = sel.sys_wfi;
  assign sys_fence_o    = sel.sys_fence;

endmodule

//--- design/i_decoder.sv
`timescale 1ns/10ps

module i_decoder import decode_pkg::*; (
  input  logic [31:0]   instr_rdata_i,    // Raw instruction word
  output decoder_ctrl_t decoder_ctrl_o    // RV32I candidate
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          f7_zero;     // Plain encoding
  logic          f7_alt;      // SUB / SRA encoding
  logic          rs1_zero;
  logic          illegal;
  decoder_ctrl_t ctrl;

  assign opcode   = instr_rdata_i[6:0];
  assign funct3   = instr_rdata_i[14:12];
  assign funct7   = instr_rdata_i[31:25];
  assign f7_zero  = (funct7 == 7'b0000000);
  assign f7_alt   = (funct7 == 7'b0100000);
  assign rs1_zero = (instr_rdata_i[19:15] == 5'd0);

  always_comb begin
    ctrl    = DECODER_CTRL_NONE;
    illegal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: begin   // U/J formats, rd only
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
      end
      OPC_JALR: begin
        ctrl.alu_en   = 1'b1;             // Link address
        ctrl.rf_we    = 1'b1;
        ctrl.rf_re[0] = 1'b1;
        illegal       = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_re  = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_operator = ALU_EQ;
          3'b001:  ctrl.alu_operator = ALU_NE;
          3'b100:  ctrl.alu_operator = ALU_LT;
          3'b101:  ctrl.alu_operator = ALU_GE;
          3'b110:  ctrl.alu_operator = ALU_LTU;
          3'b111:  ctrl.alu_operator = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.rf_re[0] = 1'b1;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        ctrl.lsu_sext = ~funct3[2];       // LBU / LHU zero extend
        illegal       = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.rf_re    = 2'b11;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP, OPC_OPIMM: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = (opcode == OPC_OP) ? 2'b11 : 2'b01;
        case (funct3)
          3'b000:  ctrl.alu_operator = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl.alu_operator = ALU_SLL;
          3'b010:  ctrl.alu_operator = ALU_SLT;
          3'b011:  ctrl.alu_operator = ALU_SLTU;
          3'b100:  ctrl.alu_operator = ALU_XOR;
          3'b101:  ctrl.alu_operator = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl.alu_operator = ALU_OR;
          default: ctrl.alu_operator = ALU_AND;
        endcase
        // Reserved funct7 bits; funct7 of 1 belongs to the M decoder
        if (opcode == OPC_OP) begin
          illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end else if (funct3 == 3'b001) begin
          illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(f7_zero || f7_alt);
        end
      end
      OPC_FENCE: begin
        ctrl.sys_en    = 1'b1;
        ctrl.sys_fence = 1'b1;
        illegal        = (funct3 != 3'b000);   // No FENCE.I here
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ctrl.sys_en = 1'b1;
          case (instr_rdata_i)             // Full word, rd and rs1 must be zero
            32'h0000_0073: ctrl.sys_ecall = 1'b1;
            32'h0010_0073: ctrl.sys_ebrk  = 1'b1;
            32'h3020_0073: ctrl.sys_mret  = 1'b1;
            32'h1050_0073: ctrl.sys_wfi   = 1'b1;
            default:       illegal        = 1'b1;
          endcase
        end else begin
          ctrl.csr_en   = 1'b1;
          ctrl.rf_we    = 1'b1;
          ctrl.rf_re[0] = ~funct3[2];     // Immediate forms take uimm instead of rs1
          case (funct3[1:0])
            2'b01:   ctrl.csr_op = CSR_OP_WRITE;
            2'b10:   ctrl.csr_op = rs1_zero ? CSR_OP_READ : CSR_OP_SET;
            2'b11:   ctrl.csr_op = rs1_zero ? CSR_OP_READ : CSR_OP_CLEAR;
            default: illegal = 1'b1;       // funct3 100
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  assign decoder_ctrl_o = illegal ? DECODER_CTRL_ILLEGAL : ctrl;

endmodule

//--- design/m_decoder.sv
`timescale 1ns/10ps

module m_decoder import decode_pkg::*; (
  input  logic [31:0]   instr_rdata_i,    // Raw instruction word
  input  logic          m_en_i,           // M extension enabled in config
  output decoder_ctrl_t decoder_ctrl_o    // RV32M candidate
);

  logic          match;     // OP with funct7 = 1
  decoder_ctrl_t ctrl;

  assign match = m_en_i &&
                 (instr_rdata_i[6:0] == OPC_OP) &&
                 (instr_rdata_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl = DECODER_CTRL_ILLEGAL;
    if (match) begin
      ctrl       = DECODER_CTRL_NONE;
      ctrl.rf_re = 2'b11;                 // Both operands from regfile
      ctrl.rf_we = 1'b1;
      // funct3[2] splits multiply and divide
      if (instr_rdata_i[14]) begin
        ctrl.div_en       = 1'b1;
        ctrl.div_operator = div_opcode_e'(instr_rdata_i[13:12]);
      end else begin
        ctrl.mul_en       = 1'b1;
        ctrl.mul_operator = mul_opcode_e'(instr_rdata_i[13:12]);
      end
    end
  end

  assign decoder_ctrl_o = ctrl;

endmodule

//--- verif/decode_checker.sv
`timescale 1ns/10ps

module decode_checker (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        instr_valid_i,
  input  logic        stall_i,
  input  logic        dec_valid_i,
  input  logic [15:0] en_i,             // Packed enables, same order as test data
  input  logic [11:0] ops_i,            // Packed operator fields
  output logic [31:0] error_count_o,
  output logic [31:0] timeout_count_o,
  output logic [31:0] pending_o         // Expected records not yet seen
);

  logic [127:0] name_q [$];
  logic [27:0]  exp_q  [$];
  int           err_cnt  = 0;
  int           tout_cnt = 0;
  int           pend_cnt = 0;
  logic         acc_q    = 1'b0;   // Previous edge accepted an instruction
  logic         hold_q   = 1'b0;   // Previous edge was stalled
  logic         idle_q   = 1'b0;   // Previous edge was a bubble or reset
  logic [28:0]  last_q   = '0;     // Valid plus outputs at the last sample
  logic [127:0] cur_name = "none";
  logic [27:0]  cur_exp;
  logic [27:0]  act;

  assign act             = {en_i, ops_i};
  assign error_count_o   = err_cnt;
  assign timeout_count_o = tout_cnt;
  assign pending_o       = pend_cnt;

  ////////////////////////////////////////
  // Calls from the stimulus side
  ////////////////////////////////////////

  task automatic push_expected(input logic [127:0] name, input logic [15:0] en,
                               input logic [11:0] ops);
    name_q.push_back(name);
    exp_q.push_back({en, ops});
    pend_cnt++;
  endtask

  task automatic check_read(input logic [127:0] name, input logic [31:0] exp,
                            input logic [31:0] act_dat);
    if (act_dat !== exp) begin
      $display("[ERROR] %0s: expected %h, actual %h", name, exp, act_dat);
      err_cnt++;
    end
  endtask

  task automatic note_timeout(input logic [127:0] what);
    $display("Timeout: no response within 20 cycles while running %0s", what);
    tout_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("%0s", msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Inputs are driven after the edge, so they are settled here
  always @(posedge clk) begin
    acc_q  <= !reset_i && instr_valid_i && !stall_i;
    hold_q <= !reset_i && stall_i;
    idle_q <= reset_i || (!instr_valid_i && !stall_i);
  end

  // Registered outputs are stable at the falling edge
  always @(negedge clk) begin
    if (acc_q) begin
      if (exp_q.size() == 0) begin
        $display("Decoded output appeared with no instruction expected");
        err_cnt++;
      end else begin
        cur_name = name_q.pop_front();
        cur_exp  = exp_q.pop_front();
        pend_cnt--;
        if (dec_valid_i !== 1'b1) begin
          $display("[ERROR] %0s valid: expected 1, actual %b", cur_name, dec_valid_i);
          err_cnt++;
        end
        if (act !== cur_exp) begin
          $display("[ERROR] %0s: expected en=%h ops=%h, actual en=%h ops=%h",
                   cur_name, cur_exp[27:12], cur_exp[11:0], en_i, ops_i);
          err_cnt++;
        end
      end
    end else if (hold_q && ({dec_valid_i, act} !== last_q)) begin
      $display("[ERROR] %0s stall hold: expected %h, actual %h",   // Output moved under stall
               cur_name, last_q, {dec_valid_i, act});
      err_cnt++;
    end else if (idle_q && ({dec_valid_i, act} !== 29'd0)) begin
      $display("[ERROR] bubble after %0s: expected %h, actual %h",
               cur_name, 29'd0, {dec_valid_i, act});
      err_cnt++;
    end
    last_q = {dec_valid_i, act};
  end

endmodule

//--- verif/decode_testdata.txt
# W name adr data | R name adr expected | I name word fetch_err stall_cycles en ops (hex, stall dec)
# en: illegal alu mul div lsu lsu_we lsu_sext rf_we rf_re[1:0] csr ecall ebrk mret wfi fence
# ops: alu_op[11:8] mul_op[7:6] div_op[5:4] lsu_size[3:2] csr_op[1:0]
R cfg_reset 0 00000002
I add 003100b3 0 0 41c0 000
I sub 403100b3 0 0 41c0 100
I slti fff32293 0 0 4140 300
I lw 00812383 0 0 0b40 008
I sb 00510223 0 0 0cc0 000
I beq 00208463 0 0 40c0 a00
I jal 010000ef 0 0 4100 000
I csrrw 300312f3 0 0 0160 001
I ecall 00000073 0 0 0010 000
I mret 30200073 0 0 0004 000
I mul 023100b3 0 0 21c0 000
I mulhu 023130b3 0 0 21c0 0c0
I div 023140b3 0 0 11c0 000
I remu 023170b3 0 0 11c0 030
I sub_stall 403100b3 0 3 41c0 100
W cfg_m_off 0 00000000
R cfg_m_off_rd 0 00000000
I mul_no_m 023100b3 0 0 8000 000
I div_no_m 023140b3 0 0 8000 000
W cfg_e_m 0 00000003
R cfg_e_m_rd 0 00000003
I add_rd17 003108b3 0 0 8000 000
I add_rs2_17 011100b3 0 2 8000 000
I add_x15 00d707b3 0 0 41c0 000
I lui_x16 fffff837 0 0 8000 000
I lui_x5 fffff2b7 0 0 4100 000
I ferr_add 003100b3 1 0 0000 000
I ferr_bad ffffffff 1 0 0000 000
R ill_cnt 1 00000005
R ill_last 2 fffff837
W ill_clr 1 00000000
R ill_cnt_clr 1 00000000
I bad_word ffffffff 0 0 8000 000
R ill_cnt_one 1 00000001
R ill_last_bad 2 ffffffff
R unused 3 00000000

//--- verif/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

  localparam int TIMEOUT_CYCLES = 20;

  logic        clk;
  logic        reset_i;
  logic        instr_valid;
  logic [31:0] instr_rdata;
  logic        fetch_err;
  logic        stall;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [31:0] wb_rdat;
  logic        wb_ack;
  logic        dec_valid;
  logic        illegal_insn, alu_en, mul_en, div_en, lsu_en, lsu_we, lsu_sext, rf_we, csr_en;
  logic        sys_ecall, sys_ebrk, sys_mret, sys_wfi, sys_fence;
  logic [3:0]  alu_operator;
  logic [1:0]  mul_operator, div_operator, lsu_size, csr_op, rf_re;
  logic [31:0] err_count, tout_count, pending;

  decode_stage u_dut (
    .clk (clk), .reset_i (reset_i),
    .instr_valid_i (instr_valid), .instr_rdata_i (instr_rdata),
    .fetch_err_i (fetch_err), .stall_i (stall), .dec_valid_o (dec_valid),
    .illegal_insn_o (illegal_insn), .alu_en_o (alu_en), .alu_operator_o (alu_operator),
    .mul_en_o (mul_en), .mul_operator_o (mul_operator),
    .div_en_o (div_en), .div_operator_o (div_operator),
    .lsu_en_o (lsu_en), .lsu_we_o (lsu_we), .lsu_size_o (lsu_size), .lsu_sext_o (lsu_sext),
    .rf_we_o (rf_we), .rf_re_o (rf_re), .csr_en_o (csr_en), .csr_op_o (csr_op),
    .sys_ecall_o (sys_ecall), .sys_ebrk_o (sys_ebrk), .sys_mret_o (sys_mret),
    .sys_wfi_o (sys_wfi), .sys_fence_o (sys_fence),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat), .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack)
  );

  decode_checker u_chk (
    .clk (clk), .reset_i (reset_i), .instr_valid_i (instr_valid), .stall_i (stall),
    .dec_valid_i (dec_valid),
    .en_i ({illegal_insn, alu_en, mul_en, div_en, lsu_en, lsu_we, lsu_sext, rf_we, rf_re,
            csr_en, sys_ecall, sys_ebrk, sys_mret, sys_wfi, sys_fence}),
    .ops_i ({alu_operator, mul_operator, div_operator, lsu_size, csr_op}),
    .error_count_o (err_count), .timeout_count_o (tout_count), .pending_o (pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  ////////////////////////////////////////
  // Bus and instruction drivers
  ////////////////////////////////////////

  // Holds cyc/stb until ack, data sampled 1 ns after the ack edge
  task automatic wb_access(input logic we, input logic [127:0] name, input logic [1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdata,
                           output logic ok);
    int n;
    n      = 0;
    ok     = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    while (!ok && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      ok = wb_ack;
      n++;
    end
    rdata  = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!ok) u_chk.note_timeout(name);
  endtask

  task automatic send_instr(input logic [127:0] name, input logic [31:0] word,
                            input logic ferr, input int stall_cycles,
                            input logic [15:0] en, input logic [11:0] ops);
    int n;
    u_chk.push_expected(name, en, ops);
    instr_valid = 1'b1;
    instr_rdata = word;
    fetch_err   = ferr;
    @(posedge clk);                       // Accepted, stall is low
    #1;
    instr_valid = 1'b0;
    instr_rdata = '0;
    fetch_err   = 1'b0;
    stall       = (stall_cycles > 0);
    for (n = 0; n < stall_cycles; n++) begin
      @(posedge clk);
      #1;
    end
    stall = 1'b0;
    n     = 0;
    while (pending != 0 && n < TIMEOUT_CYCLES) begin   // Checker consumes the record
      @(posedge clk);
      #1;
      n++;
    end
    if (pending != 0) u_chk.note_timeout(name);
  endtask

  ////////////////////////////////////////
  // Test data reader
  ////////////////////////////////////////

  initial begin
    int            fd;
    int            code;
    int            stall_cycles;
    logic [1023:0] line;
    logic [31:0]   cmd;
    logic [127:0]  name;
    logic [31:0]   adr, dat, word, rdata;
    logic [15:0]   en;
    logic [11:0]   ops;
    logic          ferr, ok;
    reset_i     = 1'b1;
    instr_valid = 1'b0;
    instr_rdata = '0;
    fetch_err   = 1'b0;
    stall       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat      = '0;
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    fd = $fopen("verif/decode_testdata.txt", "r");
    if (fd == 0) begin
      u_chk.note_failure("Could not open the test data file verif/decode_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        cmd  = '0;
        code = $fgets(line, fd);
        code = $sscanf(line, "%s", cmd);
        if (cmd == "W" || cmd == "R") begin
          code = $sscanf(line, "%s %s %h %h", cmd, name, adr, dat);
          wb_access(cmd == "W", name, adr[1:0], dat, rdata, ok);
          if (cmd == "R" && ok) u_chk.check_read(name, dat, rdata);
        end else if (cmd == "I") begin
          code = $sscanf(line, "%s %s %h %h %d %h %h",
                         cmd, name, word, ferr, stall_cycles, en, ops);
          send_instr(name, word, ferr, stall_cycles, en, ops);
        end
      end
      $fclose(fd);
    end
    $display("Errors: %0d, timeouts: %0d", err_count, tout_count);
    if (err_count == 0 && tout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
